// File: sys_bus_consts.svh
`ifndef SYS_BUS_CONSTS_SVH
`define SYS_BUS_CONSTS_SVH

// bus address and data width
`define SYS_XLEN 64

// on-chip ram, 512 words of 32 bits
`define SYS_RAM_BASE  64'h0000_0000_8000_0000
`define SYS_RAM_WORDS 512

// single-address targets
`define SYS_KEY_ADDR       64'h0000_0000_1000_0000
`define SYS_MTIME_ADDR     64'h0000_0000_0200_BFF8
`define SYS_MTIMECMP_ADDR  64'h0000_0000_0200_4000
`define SYS_MTIMECMP_RESET 64'h0000_0000_8000_0000

// plic window and register offsets
`define SYS_PLIC_BASE              64'h0000_0000_0C00_0000
`define SYS_PLIC_PENDING           64'h0000_0000_0000_1000
`define SYS_PLIC_ENABLE            64'h0000_0000_0000_2000
`define SYS_PLIC_THRESHOLD         64'h0000_0000_0020_0000
`define SYS_PLIC_CLAIM             64'h0000_0000_0020_0004
`define SYS_PLIC_CTX_ENABLE_STRIDE 64'h0000_0000_0000_0080
`define SYS_PLIC_CTX_STRIDE        64'h0000_0000_0000_1000
`define SYS_PLIC_SOURCES           6
`define SYS_PLIC_SPAN              64'h0000_0000_0040_0000

`endif

// File: sys_bus_pkg.sv
package sys_bus_pkg;

    // load/store size and extension, as encoded by the cpu
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // targets behind the bus
    typedef enum logic [2:0] {
        REG_NONE,
        REG_RAM,
        REG_KEY,
        REG_MTIME,
        REG_MTIMECMP,
        REG_PLIC
    } region_e;

endpackage

// File: bus_addr_decoder.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module bus_addr_decoder import sys_bus_pkg::*; (
    input  logic [`SYS_XLEN-1:0] bus_address,
    output region_e              region
);

    logic ram_hit;
    logic plic_hit;

    // ram and plic are ranges, the rest are single addresses
    assign ram_hit  = (bus_address >= `SYS_RAM_BASE) &&
                      (bus_address < `SYS_RAM_BASE + 4 * `SYS_RAM_WORDS);
    assign plic_hit = (bus_address >= `SYS_PLIC_BASE) &&
                      (bus_address < `SYS_PLIC_BASE + `SYS_PLIC_SPAN);

    always_comb begin
        if (ram_hit) begin
            region = REG_RAM;
        end else if (bus_address == `SYS_KEY_ADDR) begin
            region = REG_KEY;
        end else if (bus_address == `SYS_MTIME_ADDR) begin
            region = REG_MTIME;
        end else if (bus_address == `SYS_MTIMECMP_ADDR) begin
            region = REG_MTIMECMP;
        end else if (plic_hit) begin
            region = REG_PLIC;
        end else begin
            // unmapped, completes and reads zero
            region = REG_NONE;
        end
    end

endmodule

// File: bus_ram_port.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module bus_ram_port import sys_bus_pkg::*; (
    input  logic                 clock_slow,
    input  logic                 KEY0,
    input  logic                 ram_rd,
    input  logic                 ram_wr,
    input  logic [`SYS_XLEN-1:0] bus_address,
    input  ls_type_e             bus_ls_type,
    input  logic [`SYS_XLEN-1:0] bus_write_data,
    output logic [`SYS_XLEN-1:0] ram_rdata,
    output logic                 ram_last
);

    localparam int AW = $clog2(`SYS_RAM_WORDS);

    logic [31:0]   mem [0:`SYS_RAM_WORDS-1];
    logic          step;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] next_idx;
    logic [AW-1:0] waddr;
    logic [1:0]    byte_off;
    logic [31:0]   rd_word;
    logic [31:0]   shifted;
    logic [31:0]   low_word;
    logic [31:0]   wmask;
    logic [31:0]   wword;

    assign word_idx = bus_address[AW+1:2];
    assign next_idx = word_idx + 1'b1;
    assign byte_off = bus_address[1:0];
    assign rd_word  = mem[word_idx];
    assign shifted  = rd_word >> {byte_off, 3'b000};

    // double accesses finish on the second word
    assign ram_last = (ram_rd || ram_wr) && ((bus_ls_type != LS_D) || step);

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            step <= 1'b0;
        end else if (step) begin
            step <= 1'b0;
        end else if ((ram_rd || ram_wr) && (bus_ls_type == LS_D)) begin
            step <= 1'b1;
        end
    end

    // low half of a double load, kept for the second step
    always_ff @(posedge clock_slow) begin
        if (ram_rd && !step) begin
            low_word <= rd_word;
        end
    end

    // store lanes
    always_comb begin
        waddr = step ? next_idx : word_idx;
        case (bus_ls_type)
            LS_B, LS_BU: begin
                wmask = 32'h0000_00FF << {byte_off, 3'b000};
                wword = {4{bus_write_data[7:0]}};
            end
            LS_H, LS_HU: begin
                wmask = 32'h0000_FFFF << {byte_off[1], 4'b0000};
                wword = {2{bus_write_data[15:0]}};
            end
            default: begin
                wmask = 32'hFFFF_FFFF;
                wword = step ? bus_write_data[63:32] : bus_write_data[31:0];
            end
        endcase
    end

    always_ff @(posedge clock_slow) begin
        if (ram_wr) begin
            mem[waddr] <= (mem[waddr] & ~wmask) | (wword & wmask);
        end
    end

    // load extension
    always_comb begin
        case (bus_ls_type)
            LS_B:    ram_rdata = {{56{shifted[7]}}, shifted[7:0]};
            LS_BU:   ram_rdata = {56'b0, shifted[7:0]};
            LS_H:    ram_rdata = {{48{shifted[15]}}, shifted[15:0]};
            LS_HU:   ram_rdata = {48'b0, shifted[15:0]};
            LS_W:    ram_rdata = {{32{rd_word[31]}}, rd_word};
            LS_D:    ram_rdata = {mem[next_idx], low_word};
            default: ram_rdata = {32'b0, rd_word};
        endcase
    end

endmodule

// File: plic_regs.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module plic_regs (
    input  logic                 clock_slow,
    input  logic                 KEY0,
    input  logic                 plic_rd,
    input  logic                 plic_wr,
    input  logic [`SYS_XLEN-1:0] bus_address,
    input  logic [`SYS_XLEN-1:0] bus_write_data,
    input  logic                 ext_irq,
    output logic [`SYS_XLEN-1:0] plic_rdata,
    output logic                 meip_interrupt,
    output logic                 msip_interrupt
);

    localparam int CTX = 2;

    logic [2:0]           prio [0:`SYS_PLIC_SOURCES-1];
    logic [31:0]          pending;
    logic [31:0]          enable [0:CTX-1];
    logic [2:0]           thresh [0:CTX-1];
    logic                 irq_s;
    logic                 irq_q;
    logic [`SYS_XLEN-1:0] off;
    logic [2:0]           prio_id;
    logic                 prio_sel;
    logic                 pend_sel;
    logic [CTX-1:0]       en_sel;
    logic [CTX-1:0]       thr_sel;
    logic [CTX-1:0]       claim_sel;
    logic [CTX-1:0]       claim;
    logic                 claim_clear;

    assign off      = bus_address - `SYS_PLIC_BASE;
    assign prio_id  = off[4:2];
    assign prio_sel = off < 4 * `SYS_PLIC_SOURCES;
    assign pend_sel = off == `SYS_PLIC_PENDING;

    // only source 1 is wired, so a claim returns id 1 or nothing
    always_comb begin
        for (int c = 0; c < CTX; c++) begin
            en_sel[c]    = off == `SYS_PLIC_ENABLE + c * `SYS_PLIC_CTX_ENABLE_STRIDE;
            thr_sel[c]   = off == `SYS_PLIC_THRESHOLD + c * `SYS_PLIC_CTX_STRIDE;
            claim_sel[c] = off == `SYS_PLIC_CLAIM + c * `SYS_PLIC_CTX_STRIDE;
            claim[c]     = pending[1] && enable[c][1];
        end
    end

    assign claim_clear    = plic_rd && |(claim_sel & claim);
    assign meip_interrupt = claim[0];
    assign msip_interrupt = claim[1];

    always_comb begin
        plic_rdata = '0;
        if (prio_sel) plic_rdata = {{(`SYS_XLEN-3){1'b0}}, prio[prio_id]};
        if (pend_sel) plic_rdata = {{(`SYS_XLEN-32){1'b0}}, pending};
        for (int c = 0; c < CTX; c++) begin
            if (en_sel[c]) plic_rdata = {{(`SYS_XLEN-32){1'b0}}, enable[c]};
            if (thr_sel[c]) plic_rdata = {{(`SYS_XLEN-3){1'b0}}, thresh[c]};
            if (claim_sel[c]) plic_rdata = {{(`SYS_XLEN-1){1'b0}}, claim[c]};
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < `SYS_PLIC_SOURCES; i++) prio[i] <= '0;
            for (int c = 0; c < CTX; c++) begin
                enable[c] <= '0;
                thresh[c] <= '0;
            end
            pending <= '0;
            irq_s   <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            // rising edge of the external line marks id 1 pending
            irq_s <= ext_irq;
            irq_q <= irq_s;
            if (irq_s && !irq_q) pending[1] <= 1'b1;
            if (claim_clear) pending[1] <= 1'b0;
            if (plic_wr) begin
                if (prio_sel) prio[prio_id] <= bus_write_data[2:0];
                for (int c = 0; c < CTX; c++) begin
                    if (en_sel[c]) enable[c] <= bus_write_data[31:0];
                    if (thr_sel[c]) thresh[c] <= bus_write_data[2:0];
                end
            end
        end
    end

endmodule

// File: bus_target_control.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module bus_target_control import sys_bus_pkg::*; (
    input  logic                 clock_slow,
    input  logic                 KEY0,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  logic [`SYS_XLEN-1:0] bus_write_data,
    input  region_e              region,
    input  logic [`SYS_XLEN-1:0] ram_rdata,
    input  logic                 ram_last,
    input  logic [`SYS_XLEN-1:0] plic_rdata,
    input  logic [`SYS_XLEN-1:0] mtime,
    input  logic [7:0]           key_ascii,
    output logic                 ram_rd,
    output logic                 ram_wr,
    output logic                 plic_rd,
    output logic                 plic_wr,
    output logic [`SYS_XLEN-1:0] bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    output logic [`SYS_XLEN-1:0] mtimecmp
);

    logic                 rd_pend;
    logic                 wr_pend;
    logic                 finish;
    logic [`SYS_XLEN-1:0] rd_sel;

    // a low done flag means that transaction is in flight
    assign rd_pend = !bus_read_done;
    assign wr_pend = !bus_write_done;

    assign ram_rd  = rd_pend && (region == REG_RAM);
    assign ram_wr  = wr_pend && (region == REG_RAM);
    assign plic_rd = rd_pend && (region == REG_PLIC);
    assign plic_wr = wr_pend && (region == REG_PLIC);

    // ram may take two steps, everything else is done at once
    assign finish = (region == REG_RAM) ? ram_last : 1'b1;

    always_comb begin
        case (region)
            REG_RAM:      rd_sel = ram_rdata;
            REG_KEY:      rd_sel = {{(`SYS_XLEN-8){1'b0}}, key_ascii};
            REG_MTIME:    rd_sel = mtime;
            REG_MTIMECMP: rd_sel = mtimecmp;
            REG_PLIC:     rd_sel = plic_rdata;
            default:      rd_sel = '0;
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            mtimecmp       <= `SYS_MTIMECMP_RESET;
        end else begin
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end else if (rd_pend && finish) begin
                bus_read_done <= 1'b1;
                bus_read_data <= rd_sel;
            end
            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end else if (wr_pend && finish) begin
                bus_write_done <= 1'b1;
                if (region == REG_MTIMECMP) mtimecmp <= bus_write_data;
            end
        end
    end

endmodule

// File: sys_bus.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module sys_bus import sys_bus_pkg::*; (
    input  logic                 clock_slow,
    input  logic                 KEY0,
    input  logic [`SYS_XLEN-1:0] bus_address,
    input  logic [`SYS_XLEN-1:0] bus_write_data,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  ls_type_e             bus_ls_type,
    input  logic [`SYS_XLEN-1:0] mtime,
    input  logic [7:0]           key_ascii,
    input  logic                 ext_irq,
    output logic [`SYS_XLEN-1:0] bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    output logic [`SYS_XLEN-1:0] mtimecmp,
    output logic                 meip_interrupt,
    output logic                 msip_interrupt
);

    region_e              region;
    logic                 ram_rd;
    logic                 ram_wr;
    logic                 plic_rd;
    logic                 plic_wr;
    logic                 ram_last;
    logic [`SYS_XLEN-1:0] ram_rdata;
    logic [`SYS_XLEN-1:0] plic_rdata;

    bus_addr_decoder u_decoder (
        .bus_address (bus_address),
        .region      (region)
    );

    bus_target_control u_control (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_write_data   (bus_write_data),
        .region           (region),
        .ram_rdata        (ram_rdata),
        .ram_last         (ram_last),
        .plic_rdata       (plic_rdata),
        .mtime            (mtime),
        .key_ascii        (key_ascii),
        .ram_rd           (ram_rd),
        .ram_wr           (ram_wr),
        .plic_rd          (plic_rd),
        .plic_wr          (plic_wr),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .mtimecmp         (mtimecmp)
    );

    bus_ram_port u_ram (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .ram_rd         (ram_rd),
        .ram_wr         (ram_wr),
        .bus_address    (bus_address),
        .bus_ls_type    (bus_ls_type),
        .bus_write_data (bus_write_data),
        .ram_rdata      (ram_rdata),
        .ram_last       (ram_last)
    );

    plic_regs u_plic (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .plic_rd        (plic_rd),
        .plic_wr        (plic_wr),
        .bus_address    (bus_address),
        .bus_write_data (bus_write_data),
        .ext_irq        (ext_irq),
        .plic_rdata     (plic_rdata),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
) (
    output logic clock_slow,
    output logic KEY0
);

    initial begin
        clock_slow = 1'b0;
        forever #(period_ns / 2) clock_slow = ~clock_slow;
    end

    // release on a rising edge once the hold time is over
    initial begin
        KEY0 = 1'b0;
        repeat (reset_cycles) @(posedge clock_slow);
        KEY0 <= 1'b1;
    end

endmodule

// File: tb_sys_bus.sv
`timescale 1ns/1ps
`include "sys_bus_consts.svh"

module tb_sys_bus import sys_bus_pkg::*; ();

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_IRQ
    } op_e;

    localparam int          timeout_cycles = 20;
    localparam logic [63:0] mtime_value    = 64'h0000_0123_4567_89AB;
    localparam logic [7:0]  key_value      = 8'hC5;
    localparam logic [63:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    logic        clock_slow;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_read_enable;
    logic        bus_write_enable;
    ls_type_e    bus_ls_type;
    logic [63:0] mtime;
    logic [7:0]  key_ascii;
    logic        ext_irq;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    logic [63:0] mtimecmp;
    logic        meip_interrupt;
    logic        msip_interrupt;

    // stimulus table with one queue per column
    string       row_name   [$];
    op_e         row_op     [$];
    logic [63:0] row_addr   [$];
    ls_type_e    row_ls     [$];
    logic [63:0] row_wdata  [$];
    logic [63:0] row_rdata  [$];
    int          row_cycles [$];
    logic [1:0]  row_irq    [$];

    // little endian byte image of the ram
    logic [7:0]  shadow [0:4*`SYS_RAM_WORDS-1];
    logic [63:0] rng_state;
    logic [1:0]  irq_state;

    tb_clock_gen #(.period_ns(40), .reset_cycles(3)) u_clock (
        .clock_slow (clock_slow),
        .KEY0       (KEY0)
    );

    sys_bus uut (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .mtime            (mtime),
        .key_ascii        (key_ascii),
        .ext_irq          (ext_irq),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .mtimecmp         (mtimecmp),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic int size_bytes(input ls_type_e ls);
        case (ls)
            LS_B, LS_BU: return 1;
            LS_H, LS_HU: return 2;
            LS_W, LS_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("mismatch in %s: expected %h, actual %h",
                               name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input op_e op, input logic [63:0] addr,
                           input ls_type_e ls, input logic [63:0] wdata,
                           input logic [63:0] rdata, input int cycles);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_ls.push_back(ls);
        row_wdata.push_back(wdata);
        row_rdata.push_back(rdata);
        row_cycles.push_back(cycles);
        row_irq.push_back(irq_state);
    endtask

    task automatic ram_store(input string name, input int off, input ls_type_e ls,
                             input logic [63:0] data);
        for (int i = 0; i < size_bytes(ls); i++) shadow[off + i] = data[8*i +: 8];
        add_row(name, OP_WRITE, `SYS_RAM_BASE + off, ls, data, '0, (ls == LS_D) ? 2 : 1);
    endtask

    // expected load value from the byte image and the extension rules
    task automatic ram_load(input string name, input int off, input ls_type_e ls);
        logic [63:0] value;
        int          n;
        n = size_bytes(ls);
        value = '0;
        for (int i = 0; i < n; i++) value[8*i +: 8] = shadow[off + i];
        if ((ls == LS_B || ls == LS_H || ls == LS_W) && value[8*n-1]) begin
            for (int i = 8 * n; i < 64; i++) value[i] = 1'b1;
        end
        add_row(name, OP_READ, `SYS_RAM_BASE + off, ls, '0, value, (ls == LS_D) ? 2 : 1);
    endtask

    task automatic build_table();
        irq_state = 2'b00;
        // narrow stores land in one word
        rng_state = xorshift(rng_state);
        ram_store("sw base word", 'h40, LS_W, rng_state);
        rng_state = xorshift(rng_state);
        ram_store("sb lane 1", 'h41, LS_B, rng_state | 64'h80);
        rng_state = xorshift(rng_state);
        ram_store("sh lane 2", 'h42, LS_H, rng_state | 64'h8000);
        ram_load("lb lane 0", 'h40, LS_B);
        ram_load("lb lane 1", 'h41, LS_B);
        ram_load("lbu lane 1", 'h41, LS_BU);
        ram_load("lbu lane 3", 'h43, LS_BU);
        ram_load("lh lane 0", 'h40, LS_H);
        ram_load("lh lane 2", 'h42, LS_H);
        ram_load("lhu lane 2", 'h42, LS_HU);
        ram_load("lw", 'h40, LS_W);
        ram_load("lwu", 'h40, LS_WU);
        rng_state = xorshift(rng_state);
        ram_store("sd", 'h100, LS_D, rng_state);
        ram_load("ld", 'h100, LS_D);
        ram_load("lw upper half", 'h104, LS_W);
        ram_load("lwu upper half", 'h104, LS_WU);
        // timer compare and read-only windows
        add_row("mtimecmp reset", OP_READ, `SYS_MTIMECMP_ADDR, LS_D, '0,
                mtimecmp_reset, 1);
        rng_state = xorshift(rng_state);
        add_row("mtimecmp write", OP_WRITE, `SYS_MTIMECMP_ADDR, LS_D, rng_state, '0, 1);
        add_row("mtimecmp read", OP_READ, `SYS_MTIMECMP_ADDR, LS_D, '0, rng_state, 1);
        add_row("mtime window", OP_READ, `SYS_MTIME_ADDR, LS_D, '0, mtime_value, 1);
        add_row("key window", OP_READ, `SYS_KEY_ADDR, LS_D, '0, {56'b0, key_value}, 1);
        add_row("unmapped read", OP_READ, 64'h4000_0000, LS_D, '0, '0, 1);
        add_row("unmapped write", OP_WRITE, 64'h4000_0000, LS_D, rng_state, '0, 1);
        // plic registers
        add_row("prio 1 write", OP_WRITE, `SYS_PLIC_BASE + 4, LS_W, 64'h1D, '0, 1);
        add_row("prio 1 read", OP_READ, `SYS_PLIC_BASE + 4, LS_W, '0, 64'h5, 1);
        add_row("thresh 0 write", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_THRESHOLD, LS_W,
                64'h6, '0, 1);
        add_row("thresh 0 read", OP_READ, `SYS_PLIC_BASE + `SYS_PLIC_THRESHOLD, LS_W,
                '0, 64'h6, 1);
        add_row("thresh 1 write", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_THRESHOLD +
                `SYS_PLIC_CTX_STRIDE, LS_W, 64'hB, '0, 1);
        add_row("thresh 1 read", OP_READ, `SYS_PLIC_BASE + `SYS_PLIC_THRESHOLD +
                `SYS_PLIC_CTX_STRIDE, LS_W, '0, 64'h3, 1);
        add_row("enable 1 write", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE +
                `SYS_PLIC_CTX_ENABLE_STRIDE, LS_W, 64'hA5A5_0000, '0, 1);
        add_row("enable 1 read", OP_READ, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE +
                `SYS_PLIC_CTX_ENABLE_STRIDE, LS_W, '0, 64'hA5A5_0000, 1);
        add_row("enable 0 write", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE, LS_W,
                64'h2, '0, 1);
        add_row("enable 0 read", OP_READ, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE, LS_W,
                '0, 64'h2, 1);
        claim_sequence(0);
        add_row("enable 0 clear", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE, LS_W,
                '0, '0, 1);
        add_row("enable 1 set", OP_WRITE, `SYS_PLIC_BASE + `SYS_PLIC_ENABLE +
                `SYS_PLIC_CTX_ENABLE_STRIDE, LS_W, 64'h2, '0, 1);
        claim_sequence(1);
    endtask

    // irq edge, pending read, then two claims on the enabled context
    task automatic claim_sequence(input int ctx);
        logic [63:0] claim_addr;
        claim_addr = `SYS_PLIC_BASE + `SYS_PLIC_CLAIM + ctx * `SYS_PLIC_CTX_STRIDE;
        irq_state = (ctx == 0) ? 2'b01 : 2'b10;
        add_row($sformatf("irq edge ctx %0d", ctx), OP_IRQ, '0, LS_W, '0, '0, 0);
        add_row($sformatf("pending ctx %0d", ctx), OP_READ,
                `SYS_PLIC_BASE + `SYS_PLIC_PENDING, LS_W, '0, 64'h2, 1);
        irq_state = 2'b00;
        add_row($sformatf("first claim ctx %0d", ctx), OP_READ, claim_addr, LS_W,
                '0, 64'h1, 1);
        add_row($sformatf("second claim ctx %0d", ctx), OP_READ, claim_addr, LS_W,
                '0, '0, 1);
    endtask

    task automatic apply_row(input int i);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        @(posedge clock_slow);
        if (row_op[i] == OP_IRQ) begin
            ext_irq <= 1'b1;
            while (!seen && cycles < timeout_cycles) begin
                @(negedge clock_slow);
                seen = meip_interrupt || msip_interrupt;
                cycles++;
            end
            if (!seen) fail_run({row_name[i], ": interrupt line never rose"});
            @(posedge clock_slow);
            ext_irq <= 1'b0;
            @(negedge clock_slow);
        end else begin
            bus_address    <= row_addr[i];
            bus_ls_type    <= row_ls[i];
            bus_write_data <= row_wdata[i];
            bus_write_enable <= (row_op[i] == OP_WRITE);
            bus_read_enable  <= (row_op[i] == OP_READ);
            @(posedge clock_slow);
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
            while (!seen && cycles < timeout_cycles) begin
                @(negedge clock_slow);
                seen = (row_op[i] == OP_WRITE) ? bus_write_done : bus_read_done;
                if (!seen) cycles++;
            end
            if (!seen) fail_run({row_name[i], ": done flag never returned high"});
            check_value({row_name[i], " done cycles"}, row_cycles[i], cycles);
            if (row_op[i] == OP_READ) check_value(row_name[i], row_rdata[i], bus_read_data);
            if (row_op[i] == OP_WRITE && row_addr[i] == `SYS_MTIMECMP_ADDR) begin
                check_value({row_name[i], " port"}, row_wdata[i], mtimecmp);
            end
        end
        check_value({row_name[i], " irq lines"}, row_irq[i],
                    {msip_interrupt, meip_interrupt});
    endtask

    initial begin
        int waited;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        bus_ls_type      = LS_W;
        mtime            = mtime_value;
        key_ascii        = key_value;
        ext_irq          = 1'b0;
        rng_state        = 64'd15704;
        build_table();
        waited = 0;
        while (!KEY0 && waited < timeout_cycles) begin
            @(posedge clock_slow);
            waited++;
        end
        if (!KEY0) fail_run("reset was never released");
        @(negedge clock_slow);
        check_value("reset read done", 1, bus_read_done);
        check_value("reset write done", 1, bus_write_done);
        check_value("reset irq lines", 0, {msip_interrupt, meip_interrupt});
        check_value("reset mtimecmp port", mtimecmp_reset, mtimecmp);
        for (int i = 0; i < row_name.size(); i++) apply_row(i);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sys_bus.f
+incdir+.
sys_bus_pkg.sv
bus_addr_decoder.sv
bus_ram_port.sv
plic_regs.sv
bus_target_control.sv
sys_bus.sv
tb_clock_gen.sv
tb_sys_bus.sv

// File: Bender.yml
package:
  name: sys_bus

sources:
  - include_dirs:
      - .
    files:
      - sys_bus_pkg.sv
      - bus_addr_decoder.sv
      - bus_ram_port.sv
      - plic_regs.sv
      - bus_target_control.sv
      - sys_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_sys_bus.sv
